/* src/capture_params.svh */
`ifndef CAPTURE_PARAMS_SVH
`define CAPTURE_PARAMS_SVH

// Sample FIFO geometry
`define CAP_FIFO_DEPTH 16
`define CAP_FILL_W 5

// Flops between an asynchronous pin and its first use in the clk domain
`define CAP_SYNC_STAGES 2

`endif

/* src/capture_pkg.sv */
package capture_pkg;

    typedef logic [7:0] sample_t;  // Eight packed samples, or one SPI byte

    typedef logic [7:0] div_t;  // A channel samples once every div + 1 clocks

    // Address byte that opens every command
    typedef enum logic [7:0] {
        CMD_DIV    = 8'h55,
        CMD_ECHO   = 8'h56,
        CMD_STREAM = 8'h57,
        CMD_MODE   = 8'h58,  // Bit 7 enables channel 0 and bit 6 enables channel 1
        CMD_STATUS = 8'h5A
    } cmd_addr_e;

endpackage

/* src/spi_target.sv */
`include "capture_params.svh"

module spi_target import capture_pkg::*; (
    input  logic    clk,
    input  logic    i_rst_n,
    input  logic    i_sck,
    input  logic    i_ss_n,
    input  logic    i_mosi,
    input  sample_t i_tx_byte,
    output logic    o_miso,
    output logic    o_rx_valid,
    output sample_t o_rx_byte
);

    localparam int SYNC_MSB = `CAP_SYNC_STAGES - 1;

    logic [SYNC_MSB:0] sck_sync;
    logic [SYNC_MSB:0] ss_sync;
    logic [SYNC_MSB:0] mosi_sync;
    logic              sck_d;
    logic              sck_rise;
    logic              sck_fall;
    logic              ss_n_s;
    logic              mosi_s;
    logic [2:0]        bit_cnt;
    sample_t           rx_shift;
    sample_t           tx_shift;

    assign ss_n_s   = ss_sync[SYNC_MSB];
    assign mosi_s   = mosi_sync[SYNC_MSB];
    assign sck_rise = sck_sync[SYNC_MSB] & ~sck_d;
    assign sck_fall = ~sck_sync[SYNC_MSB] & sck_d;
    assign o_miso   = tx_shift[7];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            sck_sync   <= '0;
            ss_sync    <= '1;  // Deselected until the pin says otherwise
            sck_d      <= 1'b0;
            bit_cnt    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            sck_sync   <= {sck_sync[SYNC_MSB-1:0], i_sck};
            ss_sync    <= {ss_sync[SYNC_MSB-1:0], i_ss_n};
            sck_d      <= sck_sync[SYNC_MSB];
            o_rx_valid <= 1'b0;
            if (ss_n_s) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt    <= bit_cnt + 3'd1;
                o_rx_valid <= (bit_cnt == 3'd7);  // Eighth rising edge closes the byte
            end
        end
    end

    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[SYNC_MSB-1:0], i_mosi};
        if (!ss_n_s && sck_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_s};
            if (bit_cnt == 3'd7) begin
                o_rx_byte <= {rx_shift[6:0], mosi_s};
            end
        end
        if (ss_n_s) begin
            tx_shift <= i_tx_byte;  // Idle bus shows the reply MSB
        end else if (sck_fall) begin
            // A falling edge with the count at zero ends a byte, so the
            // decoder has had half an SCK period to update its reply
            if (bit_cnt == 3'd0) begin
                tx_shift <= i_tx_byte;
            end else begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

endmodule

/* src/cmd_regs.sv */
`include "capture_params.svh"

module cmd_regs import capture_pkg::*; (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_ss_n,
    input  logic                   i_rx_valid,
    input  sample_t                i_rx_byte,
    input  sample_t                i_fifo_head,
    input  logic                   i_fifo_empty,
    input  logic [`CAP_FILL_W-1:0] i_fill,
    input  logic [1:0]             i_overrun,
    output sample_t                o_tx_byte,
    output logic                   o_pop,
    output div_t                   o_div,
    output logic [1:0]             o_chan_en,
    output logic                   o_clr_overrun
);

    typedef enum logic {
        ST_ADDR,
        ST_DATA
    } state_e;

    state_e    state;
    cmd_addr_e addr;
    cmd_addr_e rx_cmd;
    sample_t   status_byte;
    sample_t   stream_byte;

    assign rx_cmd      = cmd_addr_e'(i_rx_byte);
    assign status_byte = {i_overrun[1], i_overrun[0], {(6 - `CAP_FILL_W){1'b0}}, i_fill};
    assign stream_byte = i_fifo_empty ? '0 : i_fifo_head;  // Empty FIFO reads as zero

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state         <= ST_ADDR;
            addr          <= CMD_DIV;
            o_tx_byte     <= '0;
            o_pop         <= 1'b0;
            o_div         <= '0;
            o_chan_en     <= '0;
            o_clr_overrun <= 1'b0;
        end else begin
            o_pop         <= 1'b0;
            o_clr_overrun <= 1'b0;
            if (i_ss_n) begin
                state <= ST_ADDR;  // Every transaction opens with an address
            end else if (i_rx_valid && state == ST_ADDR) begin
                addr <= rx_cmd;
                case (rx_cmd)
                    CMD_DIV, CMD_MODE, CMD_ECHO: begin
                        state <= ST_DATA;
                    end
                    CMD_STATUS: begin
                        state         <= ST_DATA;
                        o_tx_byte     <= status_byte;
                        o_clr_overrun <= 1'b1;  // Reading status acknowledges overruns
                    end
                    CMD_STREAM: begin
                        state     <= ST_DATA;
                        o_tx_byte <= stream_byte;
                        o_pop     <= !i_fifo_empty;
                    end
                    default: begin
                        state <= ST_ADDR;  // Unknown address is dropped
                    end
                endcase
            end else if (i_rx_valid) begin
                case (addr)
                    CMD_DIV: begin
                        o_div <= i_rx_byte;
                        state <= ST_ADDR;
                    end
                    CMD_MODE: begin
                        o_chan_en <= {i_rx_byte[6], i_rx_byte[7]};
                        state     <= ST_ADDR;
                    end
                    CMD_ECHO: begin
                        o_tx_byte <= i_rx_byte;
                    end
                    CMD_STREAM: begin
                        o_tx_byte <= stream_byte;  // Dummy bytes keep the stream going
                        o_pop     <= !i_fifo_empty;
                    end
                    default: begin
                        state <= ST_DATA;  // Status ignores its trailing bytes
                    end
                endcase
            end
        end
    end

endmodule

/* src/digitizer.sv */
`include "capture_params.svh"

module digitizer import capture_pkg::*; (
    input  logic    clk,
    input  logic    i_rst_n,
    input  logic    i_comp_in,
    input  logic    i_run,
    input  div_t    i_div,
    input  logic    i_gnt,
    input  logic    i_clr_overrun,
    output logic    o_req,
    output sample_t o_byte,
    output logic    o_overrun
);

    localparam int SYNC_MSB = `CAP_SYNC_STAGES - 1;

    logic [SYNC_MSB:0] comp_sync;
    logic              comp_s;
    div_t              div_cnt;
    logic [2:0]        bit_cnt;
    sample_t           pack;
    logic              sample_stb;
    logic              byte_done;
    logic              drop;

    assign comp_s     = comp_sync[SYNC_MSB];
    assign sample_stb = i_run && (div_cnt == '0);
    assign byte_done  = sample_stb && (bit_cnt == 3'd7);
    assign drop       = byte_done && o_req && !i_gnt;  // Previous byte still waiting

    always_ff @(posedge clk) begin
        comp_sync <= {comp_sync[SYNC_MSB-1:0], i_comp_in};
        if (sample_stb) begin
            pack <= {pack[6:0], comp_s};  // First sample ends up in bit 7
        end
        if (byte_done && !drop) begin
            o_byte <= {pack[6:0], comp_s};
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            div_cnt   <= '0;
            bit_cnt   <= '0;
            o_req     <= 1'b0;
            o_overrun <= 1'b0;
        end else begin
            if (!i_run) begin
                div_cnt <= '0;
                bit_cnt <= '0;
            end else begin
                // Compare with >= so a smaller divider written mid-run still wraps
                div_cnt <= (div_cnt >= i_div) ? '0 : div_cnt + 8'd1;
                if (sample_stb) begin
                    bit_cnt <= bit_cnt + 3'd1;
                end
            end
            if (i_gnt) begin
                o_req <= 1'b0;
            end
            if (i_clr_overrun) begin
                o_overrun <= 1'b0;
            end
            if (drop) begin
                o_overrun <= 1'b1;
            end else if (byte_done) begin
                o_req <= 1'b1;
            end
        end
    end

endmodule

/* src/write_arbiter.sv */
module write_arbiter import capture_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic [1:0] i_req,
    input  sample_t    i_byte0,
    input  sample_t    i_byte1,
    input  logic       i_full,
    output logic [1:0] o_gnt,
    output logic       o_wr_en,
    output sample_t    o_wr_byte
);

    logic last;  // Channel granted most recently

    // On a tie the channel that did not go last wins
    assign o_gnt[0] = !i_full && i_req[0] && (!i_req[1] || last);
    assign o_gnt[1] = !i_full && i_req[1] && (!i_req[0] || !last);

    assign o_wr_en   = |o_gnt;
    assign o_wr_byte = o_gnt[1] ? i_byte1 : i_byte0;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            last <= 1'b1;  // Channel 0 takes the first tie
        end else if (o_gnt[0]) begin
            last <= 1'b0;
        end else if (o_gnt[1]) begin
            last <= 1'b1;
        end
    end

endmodule

/* src/sample_fifo.sv */
`include "capture_params.svh"

module sample_fifo import capture_pkg::*; (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_wr_en,
    input  sample_t                i_wr_byte,
    input  logic                   i_pop,
    output sample_t                o_head,
    output logic                   o_empty,
    output logic                   o_full,
    output logic [`CAP_FILL_W-1:0] o_fill
);

    localparam int AW = $clog2(`CAP_FIFO_DEPTH);
    localparam logic [`CAP_FILL_W-1:0] FULL_CNT = `CAP_FILL_W'(`CAP_FIFO_DEPTH);

    sample_t       mem [`CAP_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_wr;
    logic          do_pop;

    assign do_wr   = i_wr_en && !o_full;
    assign do_pop  = i_pop && !o_empty;
    assign o_head  = mem[rd_ptr];
    assign o_empty = (o_fill == '0);
    assign o_full  = (o_fill == FULL_CNT);

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            o_fill <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + AW'(1);  // Depth is a power of two so pointers wrap
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            case ({do_wr, do_pop})
                2'b10:   o_fill <= o_fill + `CAP_FILL_W'(1);
                2'b01:   o_fill <= o_fill - `CAP_FILL_W'(1);
                default: o_fill <= o_fill;
            endcase
        end
    end

endmodule

/* src/capture_top.sv */
`include "capture_params.svh"

module capture_top import capture_pkg::*; (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_capture_en,
    input  logic i_comp0,
    input  logic i_comp1,
    input  logic i_sck,
    input  logic i_ss_n,
    input  logic i_mosi,
    output logic o_miso
);

    logic                   rx_valid;
    sample_t                rx_byte;
    sample_t                tx_byte;
    logic                   pop;
    div_t                   div;
    logic [1:0]             chan_en;
    logic                   clr_overrun;
    logic [1:0]             run;
    logic [1:0]             req;
    logic [1:0]             gnt;
    logic [1:0]             overrun;
    sample_t                byte0;
    sample_t                byte1;
    logic                   wr_en;
    sample_t                wr_byte;
    sample_t                fifo_head;
    logic                   fifo_empty;
    logic                   fifo_full;
    logic [`CAP_FILL_W-1:0] fill;

    assign run = {i_capture_en & chan_en[1], i_capture_en & chan_en[0]};

    spi_target spi_target_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_sck      (i_sck),
        .i_ss_n     (i_ss_n),
        .i_mosi     (i_mosi),
        .i_tx_byte  (tx_byte),
        .o_miso     (o_miso),
        .o_rx_valid (rx_valid),
        .o_rx_byte  (rx_byte)
    );

    cmd_regs cmd_regs_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_ss_n        (i_ss_n),
        .i_rx_valid    (rx_valid),
        .i_rx_byte     (rx_byte),
        .i_fifo_head   (fifo_head),
        .i_fifo_empty  (fifo_empty),
        .i_fill        (fill),
        .i_overrun     (overrun),
        .o_tx_byte     (tx_byte),
        .o_pop         (pop),
        .o_div         (div),
        .o_chan_en     (chan_en),
        .o_clr_overrun (clr_overrun)
    );

    digitizer digitizer0_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_comp_in     (i_comp0),
        .i_run         (run[0]),
        .i_div         (div),
        .i_gnt         (gnt[0]),
        .i_clr_overrun (clr_overrun),
        .o_req         (req[0]),
        .o_byte        (byte0),
        .o_overrun     (overrun[0])
    );

    digitizer digitizer1_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_comp_in     (i_comp1),
        .i_run         (run[1]),
        .i_div         (div),
        .i_gnt         (gnt[1]),
        .i_clr_overrun (clr_overrun),
        .o_req         (req[1]),
        .o_byte        (byte1),
        .o_overrun     (overrun[1])
    );

    write_arbiter write_arbiter_i (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_req     (req),
        .i_byte0   (byte0),
        .i_byte1   (byte1),
        .i_full    (fifo_full),
        .o_gnt     (gnt),
        .o_wr_en   (wr_en),
        .o_wr_byte (wr_byte)
    );

    sample_fifo sample_fifo_i (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (wr_en),
        .i_wr_byte (wr_byte),
        .i_pop     (pop),
        .o_head    (fifo_head),
        .o_empty   (fifo_empty),
        .o_full    (fifo_full),
        .o_fill    (fill)
    );

endmodule

/* sim/capture_properties.sv */
module capture_properties (
    input logic       clk,
    input logic       i_rst_n,
    input logic [1:0] i_gnt,
    input logic       i_wr_en,
    input logic       i_full,
    input logic       i_rx_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    gnt_onehot: assert property (@(posedge clk) disable iff (!i_rst_n) $onehot0(i_gnt))
        else $error("Arbiter granted both channels in the same cycle");

    no_write_when_full: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_wr_en && i_full))
        else $error("FIFO written while full");

    // A received byte is announced for exactly one cycle
    rx_valid_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rx_valid |=> !i_rx_valid)
        else $error("SPI receive strobe lasted two cycles");

endmodule

/* sim/capture_tb.sv */
module capture_tb import capture_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_SCK  = 8;
    localparam int MAX_WAIT  = 4096;
    localparam int MAX_LINES = 1000;
    localparam int MAX_RUN   = 100000;

    logic clk;
    logic i_rst_n;
    logic i_capture_en;
    logic i_comp0;
    logic i_comp1;
    logic i_sck;
    logic i_ss_n;
    logic i_mosi;
    logic o_miso;

    int errors;
    int checks;

    capture_top capture_top_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_capture_en (i_capture_en),
        .i_comp0      (i_comp0),
        .i_comp1      (i_comp1),
        .i_sck        (i_sck),
        .i_ss_n       (i_ss_n),
        .i_mosi       (i_mosi),
        .o_miso       (o_miso)
    );

    bind capture_top capture_properties capture_properties_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_gnt      (gnt),
        .i_wr_en    (wr_en),
        .i_full     (fifo_full),
        .i_rx_valid (rx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Returns 1 ns after a rising edge, where inputs are driven
    task automatic wait_cycles(input int n);
        int i;
        i = 0;
        while (i < n && i < MAX_WAIT) begin
            @(posedge clk);
            #1;
            i++;
        end
        if (n > MAX_WAIT) begin
            errors++;
            $display("Wait of %0d cycles exceeds the limit of %0d cycles", n, MAX_WAIT);
        end
    endtask

    // Sends one mode 0 byte and samples MISO just before each rising SCK edge
    task automatic spi_byte(input sample_t tx, input bit chk, input sample_t exp);
        sample_t rx;
        for (int b = 7; b >= 0; b--) begin
            i_mosi = tx[b];
            wait_cycles(HALF_SCK);
            rx[b] = o_miso;
            i_sck = 1'b1;
            wait_cycles(HALF_SCK);
            i_sck = 1'b0;
        end
        if (chk) begin
            checks++;
            assert (rx === exp) else begin
                errors++;
                $display("Error at %0t: o_miso byte expected %h got %h", $time, exp, rx);
            end
        end
    endtask

    // Enable rises two cycles late so the first sample is pattern bit 31
    task automatic run_pattern(input logic [31:0] pat0, input logic [31:0] pat1, input int n);
        for (int j = 0; j < n + 2; j++) begin
            i_comp0      = (j < n) ? pat0[31 - (j % 32)] : 1'b0;
            i_comp1      = (j < n) ? pat1[31 - (j % 32)] : 1'b0;
            i_capture_en = (j >= 2);
            wait_cycles(1);
        end
        i_capture_en = 1'b0;
    endtask

    initial begin
        int          fd;
        int          code;
        logic [7:0]  kind;
        int          lines;
        int          n;
        int          chk;
        bit          done;
        string       text;
        sample_t     tx;
        sample_t     exp;
        logic [31:0] pat0;
        logic [31:0] pat1;
        void'($urandom(49));
        errors       = 0;
        checks       = 0;
        i_rst_n      = 1'b0;
        i_capture_en = 1'b0;
        i_comp0      = 1'b0;
        i_comp1      = 1'b0;
        i_sck        = 1'b0;
        i_ss_n       = 1'b1;
        i_mosi       = 1'b0;
        wait_cycles(4);
        i_rst_n = 1'b1;
        wait_cycles(4);
        fd    = $fopen("sim/capture_trace.txt", "r");
        done  = (fd == 0);
        lines = 0;
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file sim/capture_trace.txt");
        end
        while (!done && lines < MAX_LINES) begin
            lines++;
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(text, fd);
            end else if (kind == "O") begin
                i_ss_n = 1'b0;
            end else if (kind == "C") begin
                wait_cycles(HALF_SCK);
                i_ss_n = 1'b1;
                wait_cycles(HALF_SCK);
            end else if (kind == "B") begin
                code = $fscanf(fd, "%h %d %h", tx, chk, exp);
                spi_byte(tx, chk != 0, exp);
            end else if (kind == "D") begin
                code = $fscanf(fd, "%h", exp);
                spi_byte(sample_t'($urandom), 1'b1, exp);
            end else if (kind == "P") begin
                code = $fscanf(fd, "%h %h %d", pat0, pat1, n);
                run_pattern(pat0, pat1, n);
            end else if (kind == "I") begin
                code = $fscanf(fd, "%d", n);
                wait_cycles(n);
            end else begin
                errors++;
                $display("Unknown trace line type '%c' in the trace file", kind);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (checks == 0) begin
            errors++;
            $display("No reply byte was checked");
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        for (int i = 0; i < MAX_RUN; i++) begin
            @(posedge clk);
        end
        $display("Run did not finish within %0d cycles", MAX_RUN);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+src
src/capture_pkg.sv
src/spi_target.sv
src/cmd_regs.sv
src/digitizer.sv
src/write_arbiter.sv
src/sample_fifo.sv
src/capture_top.sv
sim/capture_properties.sv
sim/capture_tb.sv

/* Makefile */
TOP = capture_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* sim/capture_trace.txt */
# O = SS low, C = SS high, B mosi check expected, D expected (random MOSI)
# P pattern0 pattern1 cycles (bit 31 first), I idle cycles; values in hex
O
B 56 0 00
B A5 0 00
B 3C 1 A5
B 00 1 3C
C
# Both channels on a fresh arbiter, channel 0 first
O
B 55 0 00
B 00 0 00
B 58 0 00
B C0 0 00
C
P 12345678 9ABCDEF0 32
I 8
O
B 57 0 00
D 12
D 9A
D 34
D BC
D 56
D DE
D 78
D F0
D 00
C
# Channel 0 alone
O
B 58 0 00
B 80 0 00
C
P A5C3F00F 00000000 32
I 8
O
B 57 0 00
D A5
D C3
D F0
D 0F
D 00
C
# Divider 3 keeps every fourth bit
O
B 55 0 00
B 03 0 00
C
P 8807F19E 00000000 32
I 8
O
B 57 0 00
D CB
D 00
C
# Overrun on both channels
O
B 55 0 00
B 00 0 00
B 58 0 00
B C0 0 00
C
P F0F0F0F0 0F0F0F0F 160
I 8
O
B 5A 0 00
B 00 1 D0
C
O
B 5A 0 00
B 00 1 10
C
